/* Makefile */
TOP := tb_ex

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		--top-module $(TOP) -f ex_unit.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -Fqx '** PASS **'

clean:
	rm -rf obj_dir

/* ex_unit.f */
+incdir+verilog
verilog/ex_pkg.sv
verilog/ex_if.sv
verilog/alu.sv
verilog/divider.sv
verilog/ex_stage.sv
verilog/ex_top.sv
test/tb_clock.sv
test/tb_ex.sv

/* test/tb_clock.sv */
module tb_clock (
    output logic clk,
    output logic resetn
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_NS = 10;  // 20 ns period

    initial begin
        clk = 1'b0;
        forever #HALF_NS clk = ~clk;
    end

    // Two cycles of reset, released just after an edge
    initial begin
        resetn = 1'b0;
        repeat (2) @(posedge clk);
        #2 resetn = 1'b1;
    end
endmodule

/* test/tb_ex.sv */
module tb_ex;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_ITEMS    = 400;
    localparam int TIMEOUT_NS = N_ITEMS * 40 * 20;

    typedef struct packed {
        logic             gr_we;
        ex_pkg::reg_idx_t dest;
        ex_pkg::alu_op_t  alu_op;
        logic             is_div;
        ex_pkg::div_op_t  div_op;
        ex_pkg::mem_op_t  mem_op;
        ex_pkg::word_t    src1;
        ex_pkg::word_t    src2;
        ex_pkg::word_t    st_val;
        ex_pkg::word_t    pc;
        ex_pkg::word_t    result;
    } item_t;

    logic clk, resetn;
    logic in_valid, in_gr_we, in_is_div, in_allowin;
    ex_pkg::reg_idx_t in_dest, out_dest, fwd_dest;
    ex_pkg::alu_op_t  in_alu_op;
    ex_pkg::div_op_t  in_div_op;
    ex_pkg::mem_op_t  in_mem_op, out_mem_op;
    ex_pkg::word_t    in_src1, in_src2, in_st_val, in_pc;
    logic out_valid, out_gr_we, out_allowin;
    ex_pkg::word_t    out_result, out_pc, data_addr, data_wdata, fwd_result;
    logic [1:0]       out_addr_low2;
    ex_pkg::byte_en_t data_we;
    logic fwd_valid, fwd_is_load, fwd_div_busy, wb_flush, ertn_flush;

    item_t            exp_q[$];       // Items in flight, oldest first
    item_t            cur;            // Front of the queue
    logic             held = 1'b0;    // Stage holds cur
    logic             cur_load, cur_store;
    ex_pkg::byte_en_t cur_strobe;
    ex_pkg::word_t    cur_wdata;
    logic [31:0]      lfsr = 32'd42;
    int mismatch_count = 0;
    int protocol_count = 0;
    int n_out = 0;
    int n_flushed = 0;

    tb_clock clock0 (.clk(clk), .resetn(resetn));

    ex_top dut0 (.*);

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    // Fibonacci LFSR with taps 32 22 2 1 and one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic ex_pkg::word_t alu_model(input ex_pkg::alu_op_t op,
                                                input ex_pkg::word_t a, input ex_pkg::word_t b);
        logic [4:0] sh;
        sh = b[4:0];
        case (op)
            ex_pkg::ALU_ADD:  return a + b;
            ex_pkg::ALU_SUB:  return a - b;
            ex_pkg::ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ex_pkg::ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            ex_pkg::ALU_AND:  return a & b;
            ex_pkg::ALU_OR:   return a | b;
            ex_pkg::ALU_NOR:  return ~(a | b);
            ex_pkg::ALU_XOR:  return a ^ b;
            ex_pkg::ALU_SLL:  return a << sh;
            ex_pkg::ALU_SRL:  return a >> sh;
            ex_pkg::ALU_SRA:  return $signed(a) >>> sh;
            default:          return b;  // LUI
        endcase
    endfunction

    function automatic ex_pkg::word_t div_model(input ex_pkg::div_op_t op,
                                                input ex_pkg::word_t a, input ex_pkg::word_t b);
        logic signed [31:0] sa, sb;
        logic signed [31:0] sq, sr;
        logic               ovf;
        sa  = a;
        sb  = b;
        sq  = '0;
        sr  = '0;
        ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        if (b != 0 && !ovf) begin
            sq = sa / sb;  // Signed, truncated toward zero
            sr = sa % sb;
        end
        case (op)
            ex_pkg::DIV_W:  return (b == 0) ? 32'hffff_ffff : ovf ? a : sq;
            ex_pkg::MOD_W:  return (b == 0) ? a : ovf ? 32'd0 : sr;
            ex_pkg::DIV_WU: return (b == 0) ? 32'hffff_ffff : a / b;
            default:        return (b == 0) ? a : a % b;
        endcase
    endfunction

    // Lanes of a naturally aligned access that covers the offset
    function automatic ex_pkg::byte_en_t store_strobe(input ex_pkg::mem_op_t op,
                                                      input logic [1:0] off);
        ex_pkg::byte_en_t s;
        int               size;
        int               base;
        s = '0;
        case (op)
            ex_pkg::ST_B: size = 1;
            ex_pkg::ST_H: size = 2;
            ex_pkg::ST_W: size = 4;
            default:      size = 0;
        endcase
        base = (size == 0) ? 0 : (int'(off) / size) * size;
        for (int i = 0; i < size; i++) begin
            s[base + i] = 1'b1;
        end
        return s;
    endfunction

    function automatic ex_pkg::word_t store_data(input ex_pkg::mem_op_t op,
                                                 input ex_pkg::word_t v);
        case (op)
            ex_pkg::ST_B: return {4{v[7:0]}};
            ex_pkg::ST_H: return {2{v[15:0]}};
            default:      return v;
        endcase
    endfunction

    function automatic item_t make_item(input int n);
        item_t      it;
        logic [2:0] kind;
        logic [1:0] corner;
        it        = '0;
        kind      = 3'(take_bits(3));
        it.pc     = 32'h1c00_0000 + 32'(n) * 4;
        it.dest   = ex_pkg::reg_idx_t'(take_bits(5));
        it.gr_we  = take_bits(2) != 0;
        it.src1   = take_bits(32);
        it.src2   = take_bits(32);
        it.st_val = take_bits(32);
        it.alu_op = ex_pkg::alu_op_t'(4'(take_bits(4) % 12));
        case (kind)
            3'd3, 3'd4: begin
                it.is_div = 1'b1;
                it.div_op = ex_pkg::div_op_t'(take_bits(2));
                corner    = 2'(take_bits(2));
                if (corner == 2'd0) begin
                    it.src2 = '0;                          // Divide by zero
                end else if (corner == 2'd1) begin
                    it.src1 = 32'h8000_0000;
                    it.src2 = 32'hffff_ffff;
                end else if (corner == 2'd2) begin
                    it.src2 = {{24{it.src2[7]}}, it.src2[7:0]};  // Small divisor
                end
            end
            3'd5: begin
                it.alu_op = ex_pkg::ALU_ADD;
                it.src2   = 32'(take_bits(12));
                it.mem_op = ex_pkg::mem_op_t'(4'(1 + take_bits(3) % 5));  // LD_B..LD_HU
            end
            3'd6: begin
                it.alu_op = ex_pkg::ALU_ADD;
                it.gr_we  = 1'b0;
                it.src2   = 32'(take_bits(12));
                it.mem_op = ex_pkg::mem_op_t'(4'(6 + take_bits(2) % 3));  // ST_B..ST_W
            end
            default: ;
        endcase
        it.result = it.is_div ? div_model(it.div_op, it.src1, it.src2)
                              : alu_model(it.alu_op, it.src1, it.src2);
        return it;
    endfunction

    task automatic drive_item(input item_t it);
        in_valid  = 1'b1;
        in_gr_we  = it.gr_we;
        in_dest   = it.dest;
        in_alu_op = it.alu_op;
        in_is_div = it.is_div;
        in_div_op = it.div_op;
        in_mem_op = it.mem_op;
        in_src1   = it.src1;
        in_src2   = it.src2;
        in_st_val = it.st_val;
        in_pc     = it.pc;
    endtask

    task automatic show_front();
        held = exp_q.size() != 0;
        if (held) begin
            cur = exp_q[0];
        end
        cur_load   = cur.mem_op inside {ex_pkg::LD_B, ex_pkg::LD_H, ex_pkg::LD_W,
                                        ex_pkg::LD_BU, ex_pkg::LD_HU};
        cur_store  = cur.mem_op inside {ex_pkg::ST_B, ex_pkg::ST_H, ex_pkg::ST_W};
        cur_strobe = store_strobe(cur.mem_op, cur.result[1:0]);
        cur_wdata  = store_data(cur.mem_op, cur.st_val);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Checks sampled mid-cycle on the falling edge
    //////////////////////////////////////////////////////////////////////

    a_result: assert property (@(negedge clk) disable iff (!resetn)
        out_valid && held |-> out_result == cur.result)
    else begin
        mismatch_count++;
        $display("mismatch at %0t: out_result %h, expected %h (pc %h)",
                 $time, out_result, cur.result, cur.pc);
    end

    a_fields: assert property (@(negedge clk) disable iff (!resetn)
        out_valid && held |-> out_pc == cur.pc && out_dest == cur.dest
            && out_gr_we == cur.gr_we && out_mem_op == cur.mem_op
            && out_addr_low2 == cur.result[1:0])
    else begin
        mismatch_count++;
        $display("mismatch at %0t: fields of pc %h, expected pc %h", $time, out_pc, cur.pc);
    end

    a_fwd: assert property (@(negedge clk) disable iff (!resetn)
        held |-> fwd_valid == cur.gr_we && fwd_is_load == cur_load && fwd_dest == cur.dest
            && (!out_valid || fwd_result == cur.result))
    else begin
        mismatch_count++;
        $display("mismatch at %0t: forwarding bundle for pc %h", $time, cur.pc);
    end

    a_div_busy: assert property (@(negedge clk) disable iff (!resetn)
        !wb_flush |-> fwd_div_busy == (held && cur.is_div && !out_valid))
    else begin
        mismatch_count++;
        $display("mismatch at %0t: fwd_div_busy is %b", $time, fwd_div_busy);
    end

    a_store: assert property (@(negedge clk) disable iff (!resetn)
        held && cur_store && !wb_flush && !ertn_flush |-> data_we == cur_strobe
            && data_addr == {cur.result[31:2], 2'b00} && data_wdata == cur_wdata)
    else begin
        mismatch_count++;
        $display("mismatch at %0t: store we %h addr %h data %h, expected %h %h %h", $time,
                 data_we, data_addr, data_wdata, cur_strobe,
                 {cur.result[31:2], 2'b00}, cur_wdata);
    end

    a_no_store: assert property (@(negedge clk) disable iff (!resetn)
        !(held && cur_store) || wb_flush || ertn_flush |-> data_we == '0)
    else begin
        mismatch_count++;
        $display("mismatch at %0t: data_we %h with no store allowed", $time, data_we);
    end

    // Non-divides leave the cycle after acceptance
    a_out_valid: assert property (@(negedge clk) disable iff (!resetn)
        !wb_flush && !(held && cur.is_div) |-> out_valid == held)
    else begin
        protocol_count++;
        $display("out_valid does not match the stage contents at %0t", $time);
    end

    a_flush: assert property (@(negedge clk) disable iff (!resetn)
        wb_flush |-> !out_valid)
    else begin
        protocol_count++;
        $display("out_valid is high during a writeback flush at %0t", $time);
    end

    a_allowin: assert property (@(negedge clk) disable iff (!resetn)
        in_allowin == (!wb_flush && (!held || (out_valid && out_allowin))))
    else begin
        protocol_count++;
        $display("in_allowin is wrong for the stage state at %0t", $time);
    end

    a_hold: assert property (@(negedge clk) disable iff (!resetn)
        $past(out_valid && !out_allowin) && !wb_flush |-> out_valid && $stable(out_result)
            && $stable(out_pc) && $stable(out_dest) && $stable(out_gr_we)
            && $stable(out_mem_op) && $stable(out_addr_low2)
            && $stable(data_addr) && $stable(data_wdata))
    else begin
        protocol_count++;
        $display("outputs changed while the memory stage stalled at %0t", $time);
    end

    a_reset: assert property (@(negedge clk)
        !resetn |-> !out_valid && in_allowin && data_we == '0 && !fwd_valid && !fwd_div_busy)
    else begin
        protocol_count++;
        $display("outputs are not in their reset state at %0t", $time);
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus and report
    //////////////////////////////////////////////////////////////////////

    initial begin
        item_t offer;
        int    issued;
        logic  fire_in, fire_out, flushed;
        issued = 0;
        offer  = '0;
        drive_item(offer);
        in_valid    = 1'b0;
        out_allowin = 1'b1;
        wb_flush    = 1'b0;
        ertn_flush  = 1'b0;
        wait (resetn === 1'b1);
        while (issued < N_ITEMS || in_valid || held) begin
            @(negedge clk);
            fire_in  = in_valid && in_allowin;
            fire_out = out_valid && out_allowin;
            flushed  = wb_flush;
            @(posedge clk);
            #2;
            if (fire_out || (flushed && exp_q.size() != 0)) begin
                exp_q.delete(0);
                if (fire_out) n_out++;
                else n_flushed++;
            end
            if (fire_in) begin
                exp_q.push_back(offer);
            end
            show_front();
            // Decode holds its offer until it is taken
            if (fire_in || !in_valid) begin
                if (issued < N_ITEMS && take_bits(2) != 0) begin
                    offer = make_item(issued);
                    issued++;
                    drive_item(offer);
                end else begin
                    in_valid = 1'b0;
                end
            end
            out_allowin = take_bits(2) != 0;
            wb_flush    = take_bits(6) == 0;
            ertn_flush  = take_bits(5) == 0;
        end
        $display("errors: %0d mismatch, %0d protocol (%0d delivered, %0d flushed)",
                 mismatch_count, protocol_count, n_out, n_flushed);
        if (mismatch_count == 0 && protocol_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("** FAIL **");
        $finish;
    end

endmodule

/* verilog/alu.sv */
module alu (
    input  ex_pkg::alu_op_t op,
    input  ex_pkg::word_t   a,
    input  ex_pkg::word_t   b,
    output ex_pkg::word_t   y
);

    ex_pkg::word_t add_res;
    ex_pkg::word_t sub_res;
    logic          slt;
    logic          sltu;
    logic [4:0]    shamt;
    ex_pkg::word_t sll_res;
    ex_pkg::word_t srl_res;
    ex_pkg::word_t sra_res;

    //////////////////////////////////////////////////////////////////////
    // Arithmetic and compare
    //////////////////////////////////////////////////////////////////////

    assign add_res = a + b;
    assign sub_res = a - b;
    assign slt     = $signed(a) < $signed(b);
    assign sltu    = a < b;

    //////////////////////////////////////////////////////////////////////
    // Shifts
    //////////////////////////////////////////////////////////////////////

    assign shamt   = b[4:0];  // Only low five bits count
    assign sll_res = a << shamt;
    assign srl_res = a >> shamt;
    assign sra_res = ex_pkg::word_t'($signed(a) >>> shamt);

    //////////////////////////////////////////////////////////////////////
    // Result select
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (op)
            ex_pkg::ALU_ADD: begin
                y = add_res;
            end
            ex_pkg::ALU_SUB: begin
                y = sub_res;
            end
            ex_pkg::ALU_SLT: begin
                y = ex_pkg::word_t'(slt);
            end
            ex_pkg::ALU_SLTU: begin
                y = ex_pkg::word_t'(sltu);
            end
            ex_pkg::ALU_AND: begin
                y = a & b;
            end
            ex_pkg::ALU_OR: begin
                y = a | b;
            end
            ex_pkg::ALU_NOR: begin
                y = ~(a | b);
            end
            ex_pkg::ALU_XOR: begin
                y = a ^ b;
            end
            ex_pkg::ALU_SLL: begin
                y = sll_res;
            end
            ex_pkg::ALU_SRL: begin
                y = srl_res;
            end
            ex_pkg::ALU_SRA: begin
                y = sra_res;
            end
            ex_pkg::ALU_LUI: begin
                y = b;  // Immediate comes in pre-shifted
            end
            default: begin
                y = add_res;
            end
        endcase
    end

endmodule

/* verilog/divider.sv */
`include "ex_defs.svh"

module divider (
    input  logic            clk,
    input  logic            resetn,
    input  logic            start,
    input  logic            ack,
    input  ex_pkg::div_op_t op,
    input  ex_pkg::word_t   dividend,
    input  ex_pkg::word_t   divisor,
    output ex_pkg::word_t   result,
    output logic            busy,
    output logic            done
);

    localparam int CNT_W = $clog2(`EX_DIV_STEPS + 1);

    ex_pkg::div_state_t state;
    logic [CNT_W-1:0]   cnt;

    ex_pkg::word_t      rem;     // Partial remainder
    ex_pkg::word_t      quo;     // Dividend shifts out as the quotient shifts in
    ex_pkg::word_t      dsr;
    logic               want_rem;
    logic               q_neg;
    logic               r_neg;

    logic               is_signed;
    logic               a_neg;
    logic               b_neg;
    ex_pkg::word_t      abs_a;
    ex_pkg::word_t      abs_b;
    logic [`EX_XLEN:0]  rem_sh;
    logic [`EX_XLEN:0]  diff;
    ex_pkg::word_t      q_fix;
    ex_pkg::word_t      r_fix;

    assign is_signed = (op == ex_pkg::DIV_W) || (op == ex_pkg::MOD_W);
    assign a_neg     = is_signed & dividend[`EX_XLEN-1];
    assign b_neg     = is_signed & divisor[`EX_XLEN-1];
    assign abs_a     = a_neg ? -dividend : dividend;
    assign abs_b     = b_neg ? -divisor : divisor;

    assign rem_sh = {rem, quo[`EX_XLEN-1]};
    assign diff   = rem_sh - {1'b0, dsr};

    //////////////////////////////////////////////////////////////////////
    // Control FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= ex_pkg::DIV_IDLE;
            cnt   <= '0;
        end else if (ack) begin
            state <= ex_pkg::DIV_IDLE;  // Also aborts a flushed divide
        end else begin
            case (state)
                ex_pkg::DIV_IDLE: begin
                    if (start) begin
                        state <= ex_pkg::DIV_RUN;
                        cnt   <= '0;
                    end
                end
                ex_pkg::DIV_RUN: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_W'(`EX_DIV_STEPS - 1)) begin
                        state <= ex_pkg::DIV_DONE;
                    end
                end
                default: begin
                    state <= state;  // DONE holds until ack
                end
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Shift-subtract datapath
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (state == ex_pkg::DIV_IDLE && start) begin
            rem      <= '0;
            quo      <= abs_a;
            dsr      <= abs_b;
            want_rem <= (op == ex_pkg::MOD_W) || (op == ex_pkg::MOD_WU);
            q_neg    <= (a_neg ^ b_neg) & (divisor != '0);  // x/0 stays all ones
            r_neg    <= a_neg;
        end else if (state == ex_pkg::DIV_RUN) begin
            if (!diff[`EX_XLEN]) begin
                rem <= diff[`EX_XLEN-1:0];
                quo <= {quo[`EX_XLEN-2:0], 1'b1};
            end else begin
                rem <= rem_sh[`EX_XLEN-1:0];
                quo <= {quo[`EX_XLEN-2:0], 1'b0};
            end
        end
    end

    // Remainder takes the dividend's sign
    assign q_fix  = q_neg ? -quo : quo;
    assign r_fix  = r_neg ? -rem : rem;
    assign result = want_rem ? r_fix : q_fix;

    assign busy = (state == ex_pkg::DIV_RUN);
    assign done = (state == ex_pkg::DIV_DONE);

endmodule

/* verilog/ex_defs.svh */
`ifndef EX_DEFS_SVH
`define EX_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// Execute stage widths
//////////////////////////////////////////////////////////////////////

// Data path width
`define EX_XLEN 32

// Register file index width
`define EX_REG_BITS 5

// One quotient bit per divider step
`define EX_DIV_STEPS 32

`endif

/* verilog/ex_if.sv */
// Decode to execute
interface ex_in_if;
    logic             valid;
    logic             allowin;
    logic             gr_we;
    ex_pkg::reg_idx_t dest;
    ex_pkg::alu_op_t  alu_op;
    logic             is_div;
    ex_pkg::div_op_t  div_op;
    ex_pkg::mem_op_t  mem_op;
    ex_pkg::word_t    src1;
    ex_pkg::word_t    src2;
    ex_pkg::word_t    st_val;   // Store data from rd
    ex_pkg::word_t    pc;

    modport src (
        output valid, gr_we, dest, alu_op, is_div, div_op, mem_op,
        output src1, src2, st_val, pc,
        input  allowin
    );

    modport dst (
        input  valid, gr_we, dest, alu_op, is_div, div_op, mem_op,
        input  src1, src2, st_val, pc,
        output allowin
    );
endinterface

// Execute to memory
interface ex_out_if;
    logic             valid;
    logic             allowin;
    logic             gr_we;
    ex_pkg::reg_idx_t dest;
    ex_pkg::word_t    result;
    ex_pkg::mem_op_t  mem_op;
    logic [1:0]       addr_low2;  // Byte offset for load alignment
    ex_pkg::word_t    pc;

    modport src (
        output valid, gr_we, dest, result, mem_op, addr_low2, pc,
        input  allowin
    );

    modport dst (
        input  valid, gr_we, dest, result, mem_op, addr_low2, pc,
        output allowin
    );
endinterface

/* verilog/ex_pkg.sv */
`include "ex_defs.svh"

package ex_pkg;

    typedef logic [`EX_XLEN-1:0]     word_t;
    typedef logic [`EX_REG_BITS-1:0] reg_idx_t;
    typedef logic [3:0]              byte_en_t;  // One bit per byte lane

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLT  = 4'd2,
        ALU_SLTU = 4'd3,
        ALU_AND  = 4'd4,
        ALU_OR   = 4'd5,
        ALU_NOR  = 4'd6,
        ALU_XOR  = 4'd7,
        ALU_SLL  = 4'd8,
        ALU_SRL  = 4'd9,
        ALU_SRA  = 4'd10,
        ALU_LUI  = 4'd11
    } alu_op_t;

    typedef enum logic [1:0] {
        DIV_W  = 2'd0,
        MOD_W  = 2'd1,
        DIV_WU = 2'd2,
        MOD_WU = 2'd3
    } div_op_t;

    // Loads and stores, MEM_NONE for plain ALU work
    typedef enum logic [3:0] {
        MEM_NONE = 4'd0,
        LD_B     = 4'd1,
        LD_H     = 4'd2,
        LD_W     = 4'd3,
        LD_BU    = 4'd4,
        LD_HU    = 4'd5,
        ST_B     = 4'd6,
        ST_H     = 4'd7,
        ST_W     = 4'd8
    } mem_op_t;

    typedef enum logic [1:0] {
        DIV_IDLE = 2'd0,
        DIV_RUN  = 2'd1,
        DIV_DONE = 2'd2
    } div_state_t;

endpackage

/* verilog/ex_stage.sv */
`include "ex_defs.svh"

module ex_stage (
    input  logic             clk,
    input  logic             resetn,
    ex_in_if.dst             in_bus,
    ex_out_if.src            out_bus,
    output ex_pkg::byte_en_t data_we,
    output ex_pkg::word_t    data_addr,
    output ex_pkg::word_t    data_wdata,
    output logic             fwd_valid,
    output logic             fwd_is_load,
    output ex_pkg::reg_idx_t fwd_dest,
    output ex_pkg::word_t    fwd_result,
    output logic             fwd_div_busy,
    input  logic             wb_flush,
    input  logic             ertn_flush
);

    logic             valid_r;
    logic             gr_we_r;
    ex_pkg::reg_idx_t dest_r;
    ex_pkg::alu_op_t  alu_op_r;
    logic             is_div_r;
    ex_pkg::div_op_t  div_op_r;
    ex_pkg::mem_op_t  mem_op_r;
    ex_pkg::word_t    src1_r;
    ex_pkg::word_t    src2_r;
    ex_pkg::word_t    st_val_r;
    ex_pkg::word_t    pc_r;

    logic             ready_go;
    logic             out_fire;
    logic             div_started;
    logic             div_start;
    logic             div_ack;
    logic             div_busy;
    logic             div_done;
    ex_pkg::word_t    div_y;
    ex_pkg::word_t    alu_y;
    ex_pkg::word_t    result;
    logic             is_load;
    ex_pkg::byte_en_t strobe;

    //////////////////////////////////////////////////////////////////////
    // Handshake and stage register
    //////////////////////////////////////////////////////////////////////

    assign ready_go       = is_div_r ? div_done : 1'b1;
    assign out_bus.valid  = valid_r & ready_go & ~wb_flush;
    assign out_fire       = out_bus.valid & out_bus.allowin;
    assign in_bus.allowin = ~wb_flush & (~valid_r | out_fire);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_r <= 1'b0;
        end else if (wb_flush) begin
            valid_r <= 1'b0;
        end else if (in_bus.allowin) begin
            valid_r <= in_bus.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_bus.valid && in_bus.allowin) begin
            gr_we_r  <= in_bus.gr_we;
            dest_r   <= in_bus.dest;
            alu_op_r <= in_bus.alu_op;
            is_div_r <= in_bus.is_div;
            div_op_r <= in_bus.div_op;
            mem_op_r <= in_bus.mem_op;
            src1_r   <= in_bus.src1;
            src2_r   <= in_bus.src2;
            st_val_r <= in_bus.st_val;
            pc_r     <= in_bus.pc;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // ALU and divider
    //////////////////////////////////////////////////////////////////////

    // One start per divide, ack on leaving or flush
    assign div_start = valid_r & is_div_r & ~div_started & ~wb_flush;
    assign div_ack   = div_started & (wb_flush | out_fire);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            div_started <= 1'b0;
        end else if (div_ack) begin
            div_started <= 1'b0;
        end else if (div_start) begin
            div_started <= 1'b1;
        end
    end

    alu u_alu (
        .op (alu_op_r),
        .a  (src1_r),
        .b  (src2_r),
        .y  (alu_y)
    );

    divider u_div (
        .clk      (clk),
        .resetn   (resetn),
        .start    (div_start),
        .ack      (div_ack),
        .op       (div_op_r),
        .dividend (src1_r),
        .divisor  (src2_r),
        .result   (div_y),
        .busy     (div_busy),
        .done     (div_done)
    );

    assign result = is_div_r ? div_y : alu_y;

    //////////////////////////////////////////////////////////////////////
    // Store request
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (mem_op_r)
            ex_pkg::ST_B: begin
                strobe     = ex_pkg::byte_en_t'(4'b0001 << result[1:0]);
                data_wdata = {4{st_val_r[7:0]}};
            end
            ex_pkg::ST_H: begin
                strobe     = result[1] ? 4'b1100 : 4'b0011;
                data_wdata = {2{st_val_r[15:0]}};
            end
            ex_pkg::ST_W: begin
                strobe     = 4'b1111;
                data_wdata = st_val_r;
            end
            default: begin
                strobe     = 4'b0000;
                data_wdata = st_val_r;
            end
        endcase
    end

    assign data_we   = (valid_r & ~wb_flush & ~ertn_flush) ? strobe : 4'b0000;
    assign data_addr = {result[`EX_XLEN-1:2], 2'b00};

    // To memory stage
    assign out_bus.gr_we     = gr_we_r;
    assign out_bus.dest      = dest_r;
    assign out_bus.result    = result;
    assign out_bus.mem_op    = mem_op_r;
    assign out_bus.addr_low2 = result[1:0];
    assign out_bus.pc        = pc_r;

    // Forwarding back to decode
    assign is_load      = (mem_op_r >= ex_pkg::LD_B) && (mem_op_r <= ex_pkg::LD_HU);
    assign fwd_valid    = valid_r & gr_we_r;
    assign fwd_is_load  = valid_r & is_load;
    assign fwd_dest     = dest_r;
    assign fwd_result   = result;
    assign fwd_div_busy = valid_r & is_div_r & (div_start | div_busy);

endmodule

/* verilog/ex_top.sv */
module ex_top (
    input  logic             clk,
    input  logic             resetn,

    input  logic             in_valid,
    input  logic             in_gr_we,
    input  ex_pkg::reg_idx_t in_dest,
    input  ex_pkg::alu_op_t  in_alu_op,
    input  logic             in_is_div,
    input  ex_pkg::div_op_t  in_div_op,
    input  ex_pkg::mem_op_t  in_mem_op,
    input  ex_pkg::word_t    in_src1,
    input  ex_pkg::word_t    in_src2,
    input  ex_pkg::word_t    in_st_val,
    input  ex_pkg::word_t    in_pc,
    output logic             in_allowin,

    output logic             out_valid,
    output logic             out_gr_we,
    output ex_pkg::reg_idx_t out_dest,
    output ex_pkg::word_t    out_result,
    output ex_pkg::mem_op_t  out_mem_op,
    output logic [1:0]       out_addr_low2,
    output ex_pkg::word_t    out_pc,
    input  logic             out_allowin,

    output ex_pkg::byte_en_t data_we,
    output ex_pkg::word_t    data_addr,
    output ex_pkg::word_t    data_wdata,

    output logic             fwd_valid,
    output logic             fwd_is_load,
    output ex_pkg::reg_idx_t fwd_dest,
    output ex_pkg::word_t    fwd_result,
    output logic             fwd_div_busy,

    input  logic             wb_flush,
    input  logic             ertn_flush
);

    ex_in_if  in_if ();
    ex_out_if out_if ();

    //////////////////////////////////////////////////////////////////////
    // Decode side
    //////////////////////////////////////////////////////////////////////

    assign in_if.valid  = in_valid;
    assign in_if.gr_we  = in_gr_we;
    assign in_if.dest   = in_dest;
    assign in_if.alu_op = in_alu_op;
    assign in_if.is_div = in_is_div;
    assign in_if.div_op = in_div_op;
    assign in_if.mem_op = in_mem_op;
    assign in_if.src1   = in_src1;
    assign in_if.src2   = in_src2;
    assign in_if.st_val = in_st_val;
    assign in_if.pc     = in_pc;
    assign in_allowin   = in_if.allowin;

    // Memory side
    assign out_valid      = out_if.valid;
    assign out_gr_we      = out_if.gr_we;
    assign out_dest       = out_if.dest;
    assign out_result     = out_if.result;
    assign out_mem_op     = out_if.mem_op;
    assign out_addr_low2  = out_if.addr_low2;
    assign out_pc         = out_if.pc;
    assign out_if.allowin = out_allowin;

    ex_stage u_stage (
        .clk          (clk),
        .resetn       (resetn),
        .in_bus       (in_if),
        .out_bus      (out_if),
        .data_we      (data_we),
        .data_addr    (data_addr),
        .data_wdata   (data_wdata),
        .fwd_valid    (fwd_valid),
        .fwd_is_load  (fwd_is_load),
        .fwd_dest     (fwd_dest),
        .fwd_result   (fwd_result),
        .fwd_div_busy (fwd_div_busy),
        .wb_flush     (wb_flush),
        .ertn_flush   (ertn_flush)
    );

endmodule
